// File: source/fc_pkg.sv
`default_nettype none

package fc_pkg;

    // operand and result width
    localparam int data_width = 8;

    // product and running sum width, sums wrap here
    localparam int prod_width = 16;

    // bias enters the sum scaled by 32
    localparam int bias_shift = 5;

    // result window starts at this sum bit, round bit just below it
    localparam int frac_shift = 4;

    // product register plus relu register around the tree
    localparam int base_latency = 2;

    // ceiling of log2, number of pairwise levels for n terms
    function automatic int tree_levels(input int n);
        return $clog2(n);
    endfunction

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_hold
    } seq_state_e;

endpackage

`default_nettype wire

// File: source/fc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fc_sequencer #(
    parameter int num_taps = 50
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           in_valid,
    output logic                                           prod_en,
    output logic [fc_pkg::tree_levels(num_taps + 1) - 1:0] level_en,
    output logic                                           relu_en,
    output logic                                           flush,
    output logic                                           result_valid
);

    localparam int levels = fc_pkg::tree_levels(num_taps + 1);
    localparam int latency = levels + fc_pkg::base_latency;
    localparam int cnt_width = $clog2(latency);

    fc_pkg::seq_state_e   state;
    logic [cnt_width-1:0] cnt;
    logic                 running;

    // cnt holds the number of edges since the vector was taken
    assign running = in_valid && (state == fc_pkg::seq_run);
    assign flush   = !in_valid;
    assign prod_en = in_valid && (state == fc_pkg::seq_idle);
    assign relu_en = running && (cnt == latency - 1);

    always_comb begin
        for (int i = 0; i < levels; i++) begin
            level_en[i] = running && (cnt == i + 1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= fc_pkg::seq_idle;
            cnt          <= '0;
            result_valid <= 1'b0;
        end else if (!in_valid) begin
            // abort or end of window
            state        <= fc_pkg::seq_idle;
            cnt          <= '0;
            result_valid <= 1'b0;
        end else begin
            case (state)
                fc_pkg::seq_idle: begin
                    state <= fc_pkg::seq_run;
                    cnt   <= cnt_width'(1);
                end
                fc_pkg::seq_run: begin
                    if (relu_en) begin
                        state        <= fc_pkg::seq_hold;
                        result_valid <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                fc_pkg::seq_hold: begin
                    // result held until in_valid falls
                    state <= fc_pkg::seq_hold;
                end
                default: begin
                    state <= fc_pkg::seq_idle;
                end
            endcase
        end
    end

    a_valid_needs_window: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> $past(in_valid));

    a_one_stage_enable: assert property (@(posedge clk) disable iff (rst)
        $onehot0({prod_en, level_en, relu_en}));

endmodule

`default_nettype wire

// File: source/fc_product_bank.sv
`timescale 1ns/100ps
`default_nettype none

module fc_product_bank #(
    parameter int num_taps = 50
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      prod_en,
    input  logic                                      flush,
    input  logic [num_taps*fc_pkg::data_width-1:0]    weights,
    input  logic [num_taps*fc_pkg::data_width-1:0]    features,
    output logic [num_taps*fc_pkg::prod_width-1:0]    products
);

    localparam int dw = fc_pkg::data_width;
    localparam int pw = fc_pkg::prod_width;

    logic signed [pw-1:0] mul [num_taps];

    // one signed multiplier per tap, tap 0 in the low bits
    for (genvar i = 0; i < num_taps; i++) begin : g_mul
        logic signed [dw-1:0] w;
        logic signed [dw-1:0] f;

        assign w      = weights[i*dw +: dw];
        assign f      = features[i*dw +: dw];
        assign mul[i] = w * f;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            products <= '0;
        end else if (flush) begin
            products <= '0;
        end else if (prod_en) begin
            for (int i = 0; i < num_taps; i++) begin
                products[i*pw +: pw] <= mul[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fc_adder_tree.sv
`timescale 1ns/100ps
`default_nettype none

module fc_adder_tree #(
    parameter int num_taps = 50
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [fc_pkg::tree_levels(num_taps + 1) - 1:0] level_en,
    input  logic                                           flush,
    input  logic [num_taps*fc_pkg::prod_width-1:0]         products,
    input  logic [fc_pkg::data_width-1:0]                  bias,
    output logic [fc_pkg::prod_width-1:0]                  sum
);

    localparam int dw = fc_pkg::data_width;
    localparam int pw = fc_pkg::prod_width;
    localparam int levels = fc_pkg::tree_levels(num_taps + 1);
    localparam int leaves = 1 << levels;

    logic [pw-1:0] bias_term;
    logic [pw-1:0] leaf     [leaves];
    logic [pw-1:0] pair_sum [1:leaves-1];
    logic [pw-1:0] node     [1:leaves-1];

    // sign extended bias times 32
    assign bias_term = {{(pw - dw - fc_pkg::bias_shift){bias[dw-1]}}, bias,
                        {fc_pkg::bias_shift{1'b0}}};

    // products, then the bias term, then zero padding
    for (genvar t = 0; t < leaves; t++) begin : g_leaf
        if (t < num_taps) begin : g_prod
            assign leaf[t] = products[t*pw +: pw];
        end else if (t == num_taps) begin : g_bias
            assign leaf[t] = bias_term;
        end else begin : g_pad
            assign leaf[t] = '0;
        end
    end

    // heap numbering: node j adds children 2j and 2j+1, node 1 is the root
    for (genvar j = 1; j < leaves; j++) begin : g_pair
        if (2 * j >= leaves) begin : g_from_leaf
            assign pair_sum[j] = leaf[2*j - leaves] + leaf[2*j + 1 - leaves];
        end else begin : g_from_node
            assign pair_sum[j] = node[2*j] + node[2*j + 1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            node <= '{default: '0};
        end else if (flush) begin
            node <= '{default: '0};
        end else begin
            // level k owns nodes leaves>>k up to leaves>>(k-1) exclusive
            for (int k = 1; k <= levels; k++) begin
                if (level_en[k-1]) begin
                    for (int j = leaves >> k; j < (leaves >> (k - 1)); j++) begin
                        node[j] <= pair_sum[j];
                    end
                end
            end
        end
    end

    assign sum = node[1];

endmodule

`default_nettype wire

// File: source/fc_relu_scale.sv
`timescale 1ns/100ps
`default_nettype none

module fc_relu_scale (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          relu_en,
    input  logic                          flush,
    input  logic [fc_pkg::prod_width-1:0] sum,
    output logic [fc_pkg::data_width-1:0] result_value
);

    localparam int pw = fc_pkg::prod_width;
    localparam int mag_width = fc_pkg::data_width - 1;

    logic [mag_width-1:0] scaled;

    // window above frac_shift, plus the bit just below it for rounding
    // overflow past 7 bits wraps
    assign scaled = sum[fc_pkg::frac_shift + mag_width - 1 -: mag_width]
                  + {{(mag_width - 1){1'b0}}, sum[fc_pkg::frac_shift - 1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_value <= '0;
        end else if (flush) begin
            result_value <= '0;
        end else if (relu_en) begin
            if (sum[pw-1]) begin
                result_value <= '0;
            end else begin
                result_value <= {1'b0, scaled};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fc_neuron.sv
`timescale 1ns/100ps
`default_nettype none

module fc_neuron #(
    parameter int num_taps = 50
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  logic [num_taps*fc_pkg::data_width-1:0] weights,
    input  logic [num_taps*fc_pkg::data_width-1:0] features,
    input  logic [fc_pkg::data_width-1:0]          bias,
    output logic [fc_pkg::data_width-1:0]          result_value,
    output logic                                   result_valid
);

    localparam int levels = fc_pkg::tree_levels(num_taps + 1);

    logic                                   prod_en;
    logic [levels-1:0]                      level_en;
    logic                                   relu_en;
    logic                                   flush;
    logic [num_taps*fc_pkg::prod_width-1:0] products;
    logic [fc_pkg::prod_width-1:0]          sum;

    fc_sequencer #(
        .num_taps(num_taps)
    ) u_seq (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .prod_en     (prod_en),
        .level_en    (level_en),
        .relu_en     (relu_en),
        .flush       (flush),
        .result_valid(result_valid)
    );

    fc_product_bank #(
        .num_taps(num_taps)
    ) u_bank (
        .clk     (clk),
        .rst     (rst),
        .prod_en (prod_en),
        .flush   (flush),
        .weights (weights),
        .features(features),
        .products(products)
    );

    fc_adder_tree #(
        .num_taps(num_taps)
    ) u_tree (
        .clk     (clk),
        .rst     (rst),
        .level_en(level_en),
        .flush   (flush),
        .products(products),
        .bias    (bias),
        .sum     (sum)
    );

    fc_relu_scale u_relu (
        .clk         (clk),
        .rst         (rst),
        .relu_en     (relu_en),
        .flush       (flush),
        .sum         (sum),
        .result_value(result_value)
    );

    // idle means the datapath was flushed or never started
    a_idle_output_clear: assert property (@(posedge clk) disable iff (rst)
        (u_seq.state == fc_pkg::seq_idle) |-> (result_value == '0));

endmodule

`default_nettype wire

// File: dv/fc_neuron_tests.svh
task automatic reset_behavior();
    for (int i = 0; i < 4; i++) begin
        @(negedge clk);
        check_value("reset valid", 0, result_valid);
        check_value("reset value", 0, result_value);
    end
    rst = 1'b0;
    repeat (2) begin
        @(negedge clk);
        check_value("idle valid", 0, result_valid);
        check_value("idle value", 0, result_value);
    end
endtask

task automatic known_dot_product();
    logic [taps*dw-1:0] w;
    logic [taps*dw-1:0] f;
    logic [dw-1:0]      got;

    for (int i = 0; i < taps; i++) begin
        w[i*dw +: dw] = dw'(1);
        f[i*dw +: dw] = dw'(i);
    end
    run_vector("known dot product", w, f, '0, got);
    // result must hold while in_valid stays high
    repeat (3) begin
        @(negedge clk);
        check_value("known dot product hold valid", 1, result_valid);
        check_value("known dot product hold value", expected_result(w, f, '0), result_value);
    end
    drop_valid("known dot product");
endtask

task automatic negative_sum_and_bias();
    logic [taps*dw-1:0] w;
    logic [taps*dw-1:0] f;
    logic [dw-1:0]      got;

    for (int i = 0; i < taps; i++) begin
        w[i*dw +: dw] = dw'(1);
        f[i*dw +: dw] = dw'(1);
    end
    // -128 * 32 outweighs the 50 from the products
    run_vector("negative bias", w, f, 8'h80, got);
    check_value("negative bias relu", 0, got);
    drop_valid("negative bias");

    run_vector("bias only", '0, '0, 8'd20, got);
    check_value("bias only scaled", 40, got);
    drop_valid("bias only");
endtask

task automatic rounding_step();
    logic [taps*dw-1:0] w;
    logic [taps*dw-1:0] f;
    logic [dw-1:0]      got_hi;
    logic [dw-1:0]      got_lo;

    w = '0;
    f = '0;
    w[0 +: dw] = dw'(1);
    // sum 24 has bit 3 set, sum 16 has it clear
    f[0 +: dw] = dw'(24);
    run_vector("round up", w, f, '0, got_hi);
    drop_valid("round up");
    f[0 +: dw] = dw'(16);
    run_vector("round down", w, f, '0, got_lo);
    drop_valid("round down");
    // 24 is one step plus the round bit, 16 is exactly one step
    check_value("rounding step up", 2, got_hi);
    check_value("rounding step down", 1, got_lo);
endtask

task automatic random_vectors();
    logic [taps*dw-1:0] w;
    logic [taps*dw-1:0] f;
    logic [dw-1:0]      b;
    logic [dw-1:0]      got;
    string              name;

    for (int n = 0; n < 20; n++) begin
        for (int i = 0; i < taps; i++) begin
            w[i*dw +: dw] = dw'($urandom());
            f[i*dw +: dw] = dw'($urandom());
        end
        b = dw'($urandom());
        name = $sformatf("random vector %0d", n);
        run_vector(name, w, f, b, got);
        drop_valid(name);
    end
endtask

task automatic abort_and_restart();
    logic [taps*dw-1:0] w;
    logic [taps*dw-1:0] f;
    logic [dw-1:0]      got;

    for (int i = 0; i < taps; i++) begin
        w[i*dw +: dw] = dw'($urandom());
        f[i*dw +: dw] = dw'($urandom());
    end
    weights  = w;
    features = f;
    bias     = dw'($urandom());
    in_valid = 1'b1;
    repeat (4) begin
        @(negedge clk);
        check_value("abort window valid", 0, result_valid);
    end
    in_valid = 1'b0;
    @(negedge clk);
    check_value("abort cleared valid", 0, result_valid);
    check_value("abort cleared value", 0, result_value);

    // fresh vector straight after the abort
    for (int i = 0; i < taps; i++) begin
        w[i*dw +: dw] = dw'($urandom());
        f[i*dw +: dw] = dw'($urandom());
    end
    run_vector("restart after abort", w, f, dw'($urandom()), got);
    drop_valid("restart after abort");
endtask

// File: dv/fc_neuron_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fc_neuron_tb;

    localparam int taps = 50;
    localparam int dw = 8;
    // product register, six tree levels for 51 terms, relu register
    localparam int latency = 8;
    localparam int num_vectors = 28;
    localparam int timeout_cycles = num_vectors * 20 + 4;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic [taps*dw-1:0] weights;
    logic [taps*dw-1:0] features;
    logic [dw-1:0]      bias;
    logic [dw-1:0]      result_value;
    logic               result_valid;

    int errors;
    int checks;

    fc_neuron #(
        .num_taps(taps)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .weights     (weights),
        .features    (features),
        .bias        (bias),
        .result_value(result_value),
        .result_valid(result_valid)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s at %0t: expected %0d, actual %0d",
                     name, $time, expected, actual);
        end
    endtask

    // wrapped 16-bit sum, then relu, window above bit 4 and round on bit 3
    function automatic logic [dw-1:0] expected_result(input logic [taps*dw-1:0] w,
                                                      input logic [taps*dw-1:0] f,
                                                      input logic [dw-1:0] b);
        int          acc;
        int          wi;
        int          fi;
        int          bi;
        int          mag;
        logic [15:0] s;

        acc = 0;
        for (int i = 0; i < taps; i++) begin
            wi = $signed(w[i*dw +: dw]);
            fi = $signed(f[i*dw +: dw]);
            acc = acc + wi * fi;
        end
        bi = $signed(b);
        acc = acc + bi * 32;
        s = acc[15:0];
        if (s[15]) begin
            return '0;
        end
        mag = (int'(s) / 16 + int'(s[3])) % 128;
        return dw'(mag);
    endfunction

    // called just after a falling edge, returns just after a falling edge
    task automatic run_vector(input string name, input logic [taps*dw-1:0] w,
                              input logic [taps*dw-1:0] f, input logic [dw-1:0] b,
                              output logic [dw-1:0] got);
        weights  = w;
        features = f;
        bias     = b;
        in_valid = 1'b1;
        repeat (latency - 1) @(posedge clk);
        @(negedge clk);
        check_value({name, " early valid"}, 0, result_valid);
        @(posedge clk);
        @(negedge clk);
        check_value({name, " valid"}, 1, result_valid);
        check_value({name, " value"}, expected_result(w, f, b), result_value);
        got = result_value;
    endtask

    task automatic drop_valid(input string name);
        in_valid = 1'b0;
        @(negedge clk);
        check_value({name, " valid after drop"}, 0, result_valid);
        check_value({name, " value after drop"}, 0, result_value);
    endtask

    `include "fc_neuron_tests.svh"

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        weights  = '0;
        features = '0;
        bias     = '0;
        errors   = 0;
        checks   = 0;
        void'($urandom(1420));

        reset_behavior();
        known_dot_product();
        negative_sum_and_bias();
        rounding_step();
        random_vectors();
        abort_and_restart();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+dv
source/fc_pkg.sv
source/fc_sequencer.sv
source/fc_product_bank.sv
source/fc_adder_tree.sv
source/fc_relu_scale.sv
source/fc_neuron.sv
dv/fc_neuron_tb.sv

// File: Bender.yml
package:
  name: fc_neuron

sources:
  - files:
      - source/fc_pkg.sv
      - source/fc_sequencer.sv
      - source/fc_product_bank.sv
      - source/fc_adder_tree.sv
      - source/fc_relu_scale.sv
      - source/fc_neuron.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/fc_neuron_tb.sv
